// ==== logic/mips_pkg.sv ====
package mips_pkg;

   localparam logic [5:0] OP_RTYPE = 6'b000000;
   localparam logic [5:0] OP_J     = 6'b000010;
   localparam logic [5:0] OP_JAL   = 6'b000011;
   localparam logic [5:0] OP_BEQ   = 6'b000100;
   localparam logic [5:0] OP_BNE   = 6'b000101;
   localparam logic [5:0] OP_ADDIU = 6'b001001;
   localparam logic [5:0] OP_SLTI  = 6'b001010;
   localparam logic [5:0] OP_ANDI  = 6'b001100;
   localparam logic [5:0] OP_ORI   = 6'b001101;
   localparam logic [5:0] OP_XORI  = 6'b001110;
   localparam logic [5:0] OP_LUI   = 6'b001111;
   localparam logic [5:0] OP_LB    = 6'b100000;
   localparam logic [5:0] OP_LH    = 6'b100001;
   localparam logic [5:0] OP_LW    = 6'b100011;
   localparam logic [5:0] OP_LBU   = 6'b100100;
   localparam logic [5:0] OP_LHU   = 6'b100101;
   localparam logic [5:0] OP_SB    = 6'b101000;
   localparam logic [5:0] OP_SH    = 6'b101001;
   localparam logic [5:0] OP_SW    = 6'b101011;

   localparam logic [5:0] FN_SLL  = 6'h00;
   localparam logic [5:0] FN_SRL  = 6'h02;
   localparam logic [5:0] FN_SRA  = 6'h03;
   localparam logic [5:0] FN_JR   = 6'h08;
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_NOR  = 6'h27;
   localparam logic [5:0] FN_SLT  = 6'h2a;
   localparam logic [5:0] FN_SLTU = 6'h2b;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_t;

   typedef enum logic [1:0] {SRC_A_REG, SRC_A_FWD, SRC_A_SHAMT, SRC_A_PC} src_a_t;
   typedef enum logic [1:0] {SRC_B_REG, SRC_B_FWD, SRC_B_IMM, SRC_B_LINK} src_b_t;  // link is +4 on PC+4
   typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_t;
   typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

   typedef union packed {
      struct packed {
         logic [5:0] opcode;
         logic [4:0] rs;
         logic [4:0] rt;
         logic [4:0] rd;
         logic [4:0] shamt;
         logic [5:0] funct;
      } r;
      struct packed {
         logic [5:0]  opcode;
         logic [4:0]  rs;
         logic [4:0]  rt;
         logic [15:0] imm16;
      } i;
      struct packed {
         logic [5:0]  opcode;
         logic [25:0] target26;
      } j;
   } instr_t;

endpackage

// ==== logic/mips_alu.sv ====
`timescale 1ns/100ps

module mips_alu
   import mips_pkg::*;
(
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  alu_op_t     op,
   output logic [31:0] result,
   output logic        equal
);

   always_comb begin
      case (op)
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_NOR:  result = ~(a | b);
         ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
         ALU_SLTU: result = {31'd0, a < b};
         ALU_SLL:  result = b << a[4:0];   // shamt arrives on a
         ALU_SRL:  result = b >> a[4:0];
         ALU_SRA:  result = $signed(b) >>> a[4:0];
         ALU_LUI:  result = {b[15:0], 16'h0000};
         default:  result = a + b;
      endcase
      equal = (a == b);   // beq / bne compare
   end

endmodule

// ==== logic/mips_regfile.sv ====
`timescale 1ns/100ps

module mips_regfile (
   input  logic        CLK,
   input  logic        arst_n,
   input  logic        we,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   input  logic [4:0]  wa,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [32];

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         for (int k = 0; k < 32; k++) begin
            regs[k] <= '0;
         end
      end else if (we && wa != 5'd0) begin   // $0 stays zero
         regs[wa] <= wd;
      end
   end

   assign rd1 = regs[ra1];
   assign rd2 = regs[ra2];

endmodule

// ==== logic/mips_mem_align.sv ====
`timescale 1ns/100ps

module mips_mem_align
   import mips_pkg::*;
(
   input  logic [31:0] store_data,
   input  logic [1:0]  addr_lo,
   input  mem_size_t   size,
   input  mem_size_t   load_size,
   input  logic        load_signed,
   input  logic [1:0]  load_lo,
   input  logic [31:0] rdata,
   output logic [31:0] wdata,
   output logic [3:0]  be,
   output logic [31:0] load_value
);

   logic [7:0]  load_byte;
   logic [15:0] load_half;

   // big endian lanes, offset 0 is bits 31:24
   always_comb begin
      case (size)
         MEM_BYTE: begin
            wdata = {24'd0, store_data[7:0]} << {~addr_lo, 3'b000};
            be    = 4'b1000 >> addr_lo;
         end
         MEM_HALF: begin
            wdata = addr_lo[1] ? {16'd0, store_data[15:0]} : {store_data[15:0], 16'd0};
            be    = addr_lo[1] ? 4'b0011 : 4'b1100;
         end
         default: begin
            wdata = store_data;
            be    = 4'b1111;
         end
      endcase
   end

   assign load_byte = rdata[{~load_lo, 3'b000} +: 8];
   assign load_half = load_lo[1] ? rdata[15:0] : rdata[31:16];

   always_comb begin
      case (load_size)
         MEM_BYTE: load_value = {{24{load_signed & load_byte[7]}}, load_byte};
         MEM_HALF: load_value = {{16{load_signed & load_half[15]}}, load_half};
         default:  load_value = rdata;
      endcase
   end

endmodule

// ==== logic/mips_ctrl.sv ====
`timescale 1ns/100ps

module mips_ctrl
   import mips_pkg::*;
(
   input  logic       CLK,
   input  logic       arst_n,
   input  logic       stall,
   input  instr_t     ex_instr,
   input  logic [4:0] mw_dest,
   input  logic       mw_write,
   output alu_op_t    alu_op,
   output src_a_t     src_a,
   output src_b_t     src_b,
   output logic       imm_signed,
   output pc_sel_t    pc_sel,
   output logic [4:0] dest,
   output logic       reg_write,
   output logic       mem_re,
   output logic       mem_we,
   output mem_size_t  mem_size,
   output logic       mem_signed
);

   logic       fetch_live;   // reset vector has been presented
   logic       ex_live;      // EX holds a real fetched word
   logic       fwd_rs;
   logic       fwd_rt;
   logic       wr_dec;
   logic       re_dec;
   logic       we_dec;
   logic [5:0] opcode;
   logic [5:0] funct;

   // two-step boot, first present the vector, then drop the stale word
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         fetch_live <= 1'b0;
         ex_live    <= 1'b0;
      end else if (!stall) begin
         fetch_live <= 1'b1;
         ex_live    <= fetch_live;
      end
   end

   assign opcode = ex_instr.i.opcode;
   assign funct  = ex_instr.r.funct;
   assign fwd_rs = mw_write && (mw_dest != 5'd0) && (mw_dest == ex_instr.r.rs);
   assign fwd_rt = mw_write && (mw_dest != 5'd0) && (mw_dest == ex_instr.r.rt);

   always_comb begin
      alu_op     = ALU_ADD;
      src_a      = fwd_rs ? SRC_A_FWD : SRC_A_REG;
      src_b      = fwd_rt ? SRC_B_FWD : SRC_B_REG;
      imm_signed = 1'b1;
      pc_sel     = PC_PLUS4;
      dest       = ex_instr.i.rt;
      wr_dec     = 1'b0;
      re_dec     = 1'b0;
      we_dec     = 1'b0;
      case (opcode)
         OP_RTYPE: begin
            dest   = ex_instr.r.rd;
            wr_dec = 1'b1;
            case (funct)
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLTU: alu_op = ALU_SLTU;
               FN_JR: begin
                  pc_sel = PC_REG;   // target is operand a
                  wr_dec = 1'b0;
               end
               default: wr_dec = 1'b0;
            endcase
            if (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA)
               src_a = SRC_A_SHAMT;
         end
         OP_J: pc_sel = PC_JUMP;
         OP_JAL: begin
            pc_sel = PC_JUMP;
            dest   = 5'd31;
            wr_dec = 1'b1;
            src_a  = SRC_A_PC;
            src_b  = SRC_B_LINK;
         end
         OP_BEQ, OP_BNE: begin
            pc_sel = PC_BRANCH;   // taken decided in core
            alu_op = ALU_SUB;
         end
         OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            src_b  = SRC_B_IMM;
            wr_dec = 1'b1;
            case (opcode)
               OP_SLTI: alu_op = ALU_SLT;
               OP_ANDI: alu_op = ALU_AND;
               OP_ORI:  alu_op = ALU_OR;
               OP_XORI: alu_op = ALU_XOR;
               OP_LUI:  alu_op = ALU_LUI;
               default: alu_op = ALU_ADD;
            endcase
            imm_signed = (opcode == OP_ADDIU) || (opcode == OP_SLTI);
         end
         OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
            src_b  = SRC_B_IMM;
            wr_dec = 1'b1;
            re_dec = 1'b1;
         end
         OP_SB, OP_SH, OP_SW: begin
            src_b  = SRC_B_IMM;
            we_dec = 1'b1;
         end
         default: ;
      endcase

      case (opcode)
         OP_LB, OP_LBU, OP_SB: mem_size = MEM_BYTE;
         OP_LH, OP_LHU, OP_SH: mem_size = MEM_HALF;
         default:              mem_size = MEM_WORD;
      endcase
      mem_signed = (opcode == OP_LB) || (opcode == OP_LH);

      if (!ex_live)
         pc_sel = PC_PLUS4;   // stale word may look like a branch
      if (!fetch_live) begin
         pc_sel = PC_REG;     // ex_pc4 still holds the reset vector
         src_a  = SRC_A_PC;
      end
      reg_write = wr_dec & ex_live;
      mem_re    = re_dec & ex_live & ~stall;   // no repeated access while frozen
      mem_we    = we_dec & ex_live & ~stall;
   end

endmodule

// ==== logic/mips_core.sv ====
`timescale 1ns/100ps

module mips_core
   import mips_pkg::*;
#(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  logic        CLK,
   input  logic        arst_n,
   input  logic        stall,
   output logic [31:0] imem_addr,
   input  logic [31:0] imem_rdata,
   output logic [31:0] dmem_addr,
   output logic [31:0] dmem_wdata,
   output logic [3:0]  dmem_be,
   output logic        dmem_we,
   output logic        dmem_re,
   input  logic [31:0] dmem_rdata
);

   logic [31:0] pc;        // address of the word in imem_rdata
   logic [31:0] pc_next;
   logic [31:0] pc_plus4;
   instr_t      ex_instr;
   logic [31:0] ex_pc4;
   logic [31:0] br_target;
   logic [31:0] jump_target;
   logic        taken;

   alu_op_t     alu_op;
   src_a_t      src_a;
   src_b_t      src_b;
   logic        imm_signed;
   pc_sel_t     pc_sel;
   logic [4:0]  dest;
   logic        reg_write;
   logic        mem_re;
   logic        mem_we;
   mem_size_t   mem_size;
   logic        mem_signed;

   logic [31:0] rd1;
   logic [31:0] rd2;
   logic [31:0] imm_ext;
   logic [31:0] alu_a;
   logic [31:0] alu_b;
   logic [31:0] alu_result;
   logic        alu_equal;
   logic [31:0] store_data;

   logic [31:0] mw_result;
   logic [4:0]  mw_dest;
   logic        mw_write;
   logic        mw_load;
   mem_size_t   mw_size;
   logic        mw_signed;
   logic [31:0] load_value;
   logic [31:0] wb_value;

   mips_ctrl u_ctrl (
      .CLK        (CLK),
      .arst_n     (arst_n),
      .stall      (stall),
      .ex_instr   (ex_instr),
      .mw_dest    (mw_dest),
      .mw_write   (mw_write),
      .alu_op     (alu_op),
      .src_a      (src_a),
      .src_b      (src_b),
      .imm_signed (imm_signed),
      .pc_sel     (pc_sel),
      .dest       (dest),
      .reg_write  (reg_write),
      .mem_re     (mem_re),
      .mem_we     (mem_we),
      .mem_size   (mem_size),
      .mem_signed (mem_signed)
   );

   mips_regfile u_regfile (
      .CLK    (CLK),
      .arst_n (arst_n),
      .we     (mw_write & ~stall),
      .ra1    (ex_instr.r.rs),
      .ra2    (ex_instr.r.rt),
      .wa     (mw_dest),
      .wd     (wb_value),
      .rd1    (rd1),
      .rd2    (rd2)
   );

   mips_alu u_alu (
      .a      (alu_a),
      .b      (alu_b),
      .op     (alu_op),
      .result (alu_result),
      .equal  (alu_equal)
   );

   mips_mem_align u_align (
      .store_data  (store_data),
      .addr_lo     (alu_result[1:0]),
      .size        (mem_size),
      .load_size   (mw_size),
      .load_signed (mw_signed),
      .load_lo     (mw_result[1:0]),
      .rdata       (dmem_rdata),
      .wdata       (dmem_wdata),
      .be          (dmem_be),
      .load_value  (load_value)
   );

   assign imm_ext = imm_signed ? {{16{ex_instr.i.imm16[15]}}, ex_instr.i.imm16}
                               : {16'd0, ex_instr.i.imm16};

   always_comb begin
      case (src_a)
         SRC_A_REG:   alu_a = rd1;
         SRC_A_FWD:   alu_a = wb_value;
         SRC_A_SHAMT: alu_a = {27'd0, ex_instr.r.shamt};
         default:     alu_a = ex_pc4;
      endcase
      case (src_b)
         SRC_B_REG: alu_b = rd2;
         SRC_B_FWD: alu_b = wb_value;
         SRC_B_IMM: alu_b = imm_ext;
         default:   alu_b = 32'd4;   // PC+4 plus 4 gives the jal link
      endcase
   end

   // store data bypasses the ALU, so rt gets its own forward
   assign store_data = (mw_write && mw_dest != 5'd0 && mw_dest == ex_instr.r.rt)
                       ? wb_value : rd2;

   assign pc_plus4    = pc + 32'd4;
   assign br_target   = ex_pc4 + {imm_ext[29:0], 2'b00};
   assign jump_target = {ex_pc4[31:28], ex_instr.j.target26, 2'b00};
   assign taken       = alu_equal ^ (ex_instr.i.opcode == OP_BNE);

   always_comb begin
      case (pc_sel)
         PC_PLUS4:  pc_next = pc_plus4;
         PC_BRANCH: pc_next = taken ? br_target : pc_plus4;
         PC_JUMP:   pc_next = jump_target;
         default:   pc_next = alu_a;   // jr, or the boot vector
      endcase
   end

   assign imem_addr = pc_next;   // sync imem returns it next cycle
   assign dmem_addr = alu_result;
   assign dmem_we   = mem_we;
   assign dmem_re   = mem_re;
   assign wb_value  = mw_load ? load_value : mw_result;

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         pc       <= RESET_PC;
         ex_pc4   <= RESET_PC;
         ex_instr <= '0;        // bubble, sll $0
         mw_write <= 1'b0;
         mw_load  <= 1'b0;
      end else if (!stall) begin
         pc       <= pc_next;
         ex_pc4   <= pc_plus4;
         ex_instr <= imem_rdata;
         mw_write <= reg_write;
         mw_load  <= mem_re;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         mw_result <= alu_result;
         mw_dest   <= dest;
         mw_size   <= mem_size;
         mw_signed <= mem_signed;
      end
   end

endmodule

// ==== tests/mips_prog.svh ====
`ifndef MIPS_PROG_SVH
`define MIPS_PROG_SVH

// columns are {stores, instruction word, store address, store data, byte enables}
localparam int PROG_LEN = 75;
localparam logic [100:0] PROG [PROG_LEN] = '{
   {1'b0, 32'h24011234, 32'h00000000, 32'h00000000, 4'h0},  // addiu $1,$0,0x1234
   {1'b0, 32'h2402FFFD, 32'h00000000, 32'h00000000, 4'h0},  // addiu $2,$0,-3
   {1'b1, 32'hAC010100, 32'h00000100, 32'h00001234, 4'hF},  // sw $1
   {1'b1, 32'hAC020104, 32'h00000104, 32'hFFFFFFFD, 4'hF},  // sw $2, sign extended
   {1'b0, 32'h24230005, 32'h00000000, 32'h00000000, 4'h0},  // addiu $3,$1,5
   {1'b0, 32'h00622021, 32'h00000000, 32'h00000000, 4'h0},  // addu $4,$3,$2
   {1'b1, 32'hAC040108, 32'h00000108, 32'h00001236, 4'hF},  // sw $4 from MW
   {1'b0, 32'h00812823, 32'h00000000, 32'h00000000, 4'h0},  // subu $5,$4,$1
   {1'b0, 32'h2846FFFE, 32'h00000000, 32'h00000000, 4'h0},  // slti $6,$2,-2
   {1'b1, 32'hAC05010C, 32'h0000010C, 32'h00000002, 4'hF},  // sw $5
   {1'b1, 32'hAC060110, 32'h00000110, 32'h00000001, 4'hF},  // sw $6
   {1'b0, 32'h3047F0F0, 32'h00000000, 32'h00000000, 4'h0},  // andi $7,$2,0xf0f0
   {1'b0, 32'h34E88001, 32'h00000000, 32'h00000000, 4'h0},  // ori $8,$7,0x8001
   {1'b0, 32'h3909FFFF, 32'h00000000, 32'h00000000, 4'h0},  // xori $9,$8,0xffff
   {1'b1, 32'hAC090114, 32'h00000114, 32'h00000F0E, 4'hF},  // sw $9
   {1'b0, 32'h3C0A8765, 32'h00000000, 32'h00000000, 4'h0},  // lui $10,0x8765
   {1'b0, 32'h000A5903, 32'h00000000, 32'h00000000, 4'h0},  // sra $11,$10,4
   {1'b0, 32'h000B6202, 32'h00000000, 32'h00000000, 4'h0},  // srl $12,$11,8
   {1'b0, 32'h000C6900, 32'h00000000, 32'h00000000, 4'h0},  // sll $13,$12,4
   {1'b1, 32'hAC0D0118, 32'h00000118, 32'h0F876500, 4'hF},  // sw $13
   {1'b1, 32'hAC0B011C, 32'h0000011C, 32'hF8765000, 4'hF},  // sw $11
   {1'b0, 32'h01A27027, 32'h00000000, 32'h00000000, 4'h0},  // nor $14,$13,$2
   {1'b0, 32'h01AA7826, 32'h00000000, 32'h00000000, 4'h0},  // xor $15,$13,$10
   {1'b1, 32'hAC0F0120, 32'h00000120, 32'h88E26500, 4'hF},  // sw $15
   {1'b0, 32'h0141802A, 32'h00000000, 32'h00000000, 4'h0},  // slt $16,$10,$1
   {1'b0, 32'h0141882B, 32'h00000000, 32'h00000000, 4'h0},  // sltu $17,$10,$1
   {1'b0, 32'h01AA9024, 32'h00000000, 32'h00000000, 4'h0},  // and $18,$13,$10
   {1'b0, 32'h020E9825, 32'h00000000, 32'h00000000, 4'h0},  // or $19,$16,$14
   {1'b1, 32'hAC130124, 32'h00000124, 32'h00000003, 4'hF},  // sw $19
   {1'b1, 32'hAC110128, 32'h00000128, 32'h00000000, 4'hF},  // sw $17
   {1'b1, 32'hAC12012C, 32'h0000012C, 32'h07050000, 4'hF},  // sw $18
   {1'b0, 32'h80140200, 32'h00000000, 32'h00000000, 4'h0},  // lb $20,0x200
   {1'b1, 32'hAC140130, 32'h00000130, 32'hFFFFFF81, 4'hF},
   {1'b0, 32'h80150201, 32'h00000000, 32'h00000000, 4'h0},  // lb $21,0x201
   {1'b1, 32'hAC150134, 32'h00000134, 32'h00000072, 4'hF},
   {1'b0, 32'h90160202, 32'h00000000, 32'h00000000, 4'h0},  // lbu $22,0x202
   {1'b1, 32'hAC160138, 32'h00000138, 32'h000000F3, 4'hF},
   {1'b0, 32'h90170203, 32'h00000000, 32'h00000000, 4'h0},  // lbu $23,0x203
   {1'b1, 32'hAC17013C, 32'h0000013C, 32'h0000000E, 4'hF},
   {1'b0, 32'h84180200, 32'h00000000, 32'h00000000, 4'h0},  // lh $24,0x200
   {1'b1, 32'hAC180140, 32'h00000140, 32'hFFFF8172, 4'hF},
   {1'b0, 32'h94190202, 32'h00000000, 32'h00000000, 4'h0},  // lhu $25,0x202
   {1'b1, 32'hAC190144, 32'h00000144, 32'h0000F30E, 4'hF},
   {1'b0, 32'h841A0206, 32'h00000000, 32'h00000000, 4'h0},  // lh $26,0x206
   {1'b1, 32'hAC1A0148, 32'h00000148, 32'hFFFFC4D6, 4'hF},
   {1'b0, 32'h8C1B0204, 32'h00000000, 32'h00000000, 4'h0},  // lw $27,0x204
   {1'b1, 32'hAC1B014C, 32'h0000014C, 32'h7A5BC4D6, 4'hF},
   {1'b1, 32'hA0010150, 32'h00000150, 32'h34000000, 4'h8},  // sb $1 at each offset
   {1'b1, 32'hA0010151, 32'h00000151, 32'h00340000, 4'h4},
   {1'b1, 32'hA0010152, 32'h00000152, 32'h00003400, 4'h2},
   {1'b1, 32'hA0010153, 32'h00000153, 32'h00000034, 4'h1},
   {1'b1, 32'hA4010154, 32'h00000154, 32'h12340000, 4'hC},  // sh $1
   {1'b1, 32'hA4010156, 32'h00000156, 32'h00001234, 4'h3},
   {1'b0, 32'h10210002, 32'h00000000, 32'h00000000, 4'h0},  // beq $1,$1 taken
   {1'b1, 32'hAC010160, 32'h00000160, 32'h00001234, 4'hF},  // delay slot
   {1'b0, 32'hAC020164, 32'h00000000, 32'h00000000, 4'h0},  // skipped
   {1'b0, 32'h14210005, 32'h00000000, 32'h00000000, 4'h0},  // bne $1,$1 not taken
   {1'b1, 32'hAC030168, 32'h00000168, 32'h00001239, 4'hF},
   {1'b1, 32'hAC04016C, 32'h0000016C, 32'h00001236, 4'hF},
   {1'b0, 32'h14220002, 32'h00000000, 32'h00000000, 4'h0},  // bne $1,$2 taken
   {1'b0, 32'h241C0007, 32'h00000000, 32'h00000000, 4'h0},  // delay, addiu $28
   {1'b0, 32'hAC020170, 32'h00000000, 32'h00000000, 4'h0},  // skipped
   {1'b1, 32'hAC1C0170, 32'h00000170, 32'h00000007, 4'hF},
   {1'b0, 32'h08000042, 32'h00000000, 32'h00000000, 4'h0},  // j 0x108
   {1'b1, 32'hAC050174, 32'h00000174, 32'h00000002, 4'hF},  // delay slot
   {1'b0, 32'hAC060178, 32'h00000000, 32'h00000000, 4'h0},  // skipped
   {1'b0, 32'h0C000048, 32'h00000000, 32'h00000000, 4'h0},  // jal 0x120
   {1'b1, 32'hAC060178, 32'h00000178, 32'h00000001, 4'hF},  // delay slot
   {1'b1, 32'hAC1E017C, 32'h0000017C, 32'h00000110, 4'hF},  // link copy, after jr
   {1'b1, 32'hAC1D0180, 32'h00000180, 32'h00000ABC, 4'hF},
   {1'b0, 32'h08000046, 32'h00000000, 32'h00000000, 4'h0},  // j self, end
   {1'b0, 32'h00000000, 32'h00000000, 32'h00000000, 4'h0},
   {1'b0, 32'h27FE0000, 32'h00000000, 32'h00000000, 4'h0},  // addiu $30,$31,0
   {1'b0, 32'h03E00008, 32'h00000000, 32'h00000000, 4'h0},  // jr $31
   {1'b0, 32'h241D0ABC, 32'h00000000, 32'h00000000, 4'h0}   // delay, addiu $29
};

`endif

// ==== tests/mips_core_tb.sv ====
`timescale 1ns/100ps

module mips_core_tb;

   `include "mips_prog.svh"

   localparam int STORE_TIMEOUT = 200;   // cycles per store
   localparam int IDLE_CYCLES   = 40;

   logic        CLK = 1'b0;
   logic        arst_n = 1'b0;
   logic        stall = 1'b0;
   logic [31:0] imem_addr;
   logic [31:0] imem_rdata = '0;
   logic [31:0] dmem_addr;
   logic [31:0] dmem_wdata;
   logic [3:0]  dmem_be;
   logic        dmem_we;
   logic        dmem_re;
   logic [31:0] dmem_rdata = '0;

   logic [31:0] imem [128];
   logic [31:0] dmem [256];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [3:0]  exp_be [$];
   logic        random_stall = 1'b0;
   logic [31:0] lcg_state = 32'h9359_554c;

   mips_core #(.RESET_PC(32'h0000_0000)) uut (
      .CLK        (CLK),
      .arst_n     (arst_n),
      .stall      (stall),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_be    (dmem_be),
      .dmem_we    (dmem_we),
      .dmem_re    (dmem_re),
      .dmem_rdata (dmem_rdata)
   );

   always #20 CLK = ~CLK;

   always @(posedge CLK) begin
      if (!stall)
         imem_rdata <= imem[imem_addr[8:2]];   // held while frozen
   end

   always @(posedge CLK) begin
      if (dmem_we) begin
         for (int b = 0; b < 4; b++) begin
            if (dmem_be[b])
               dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
         end
      end
      if (dmem_re)
         dmem_rdata <= dmem[dmem_addr[9:2]];
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   always @(posedge CLK) begin
      #2;
      if (random_stall) begin
         lcg_state = lcg_next(lcg_state);
         stall <= (lcg_state[31:29] < 3'd3);   // about 3 in 8 cycles
      end else begin
         stall <= 1'b0;
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   task automatic load_program();
      logic [100:0] entry;
      for (int k = 0; k < 128; k++) begin
         imem[k] = {11'd0, 5'(k), 5'd0, 5'(k >> 5), 6'd0};   // sll $0 filler
      end
      for (int k = 0; k < PROG_LEN; k++) begin
         entry   = PROG[k];
         imem[k] = entry[99:68];
         if (entry[100]) begin
            exp_addr.push_back(entry[67:36]);
            exp_data.push_back(entry[35:4]);
            exp_be.push_back(entry[3:0]);
         end
      end
   endtask

   task automatic preload_data();
      for (int k = 0; k < 256; k++) begin
         dmem[k] <= (32'h0101_0101 * (k + 1)) ^ 32'hA5A5_0000;
      end
      dmem[8'h80] <= 32'h8172_F30E;   // 0x200
      dmem[8'h81] <= 32'h7A5B_C4D6;   // 0x204
   endtask

   task automatic run_program(input string tag);
      int  waited;
      logic found;
      arst_n = 1'b0;
      preload_data();
      repeat (10) @(posedge CLK);
      #2 arst_n = 1'b1;
      for (int j = 0; j < exp_addr.size(); j++) begin
         waited = 0;
         found  = 1'b0;
         while (!found && waited < STORE_TIMEOUT) begin
            @(negedge CLK);
            if (dmem_we)
               found = 1'b1;
            else
               waited++;
         end
         if (!found) begin
            $display("%s: store %0d to address 0x%08h never came", tag, j, exp_addr[j]);
            $display(">>> FAIL");
            $fatal(1);
         end
         check_value($sformatf("%s store %0d addr", tag, j), exp_addr[j], dmem_addr);
         check_value($sformatf("%s store %0d data", tag, j), exp_data[j], dmem_wdata);
         check_value($sformatf("%s store %0d be", tag, j), {28'd0, exp_be[j]},
                     {28'd0, dmem_be});
      end
      // program now spins in its end loop
      for (int k = 0; k < IDLE_CYCLES; k++) begin
         @(negedge CLK);
         check_value($sformatf("%s extra store", tag), 32'd0, {31'd0, dmem_we});
      end
   endtask

   initial begin
      load_program();
      run_program("plain");
      random_stall = 1'b1;
      run_program("stalled");
      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+tests
logic/mips_pkg.sv
logic/mips_alu.sv
logic/mips_regfile.sv
logic/mips_mem_align.sv
logic/mips_ctrl.sv
logic/mips_core.sv
tests/mips_core_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f filelist.f --top-module mips_core_tb -o mips_sim \
   || { echo "build failed"; exit 1; }
./obj_dir/mips_sim 2>&1 | tee sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
